// File: Bender.yml
package:
  name: mem_ahb_xfer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/mem_cmd_pkg.sv
      - rtl/mem_rd_pkg.sv
      - rtl/ahb_cmd_fetch.sv
      - rtl/ahb_burst_decode.sv
      - rtl/mem_cmd_issue.sv
      - rtl/mem_rd_return.sv
      - rtl/mem_ahb_xfer_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_mem_ahb_xfer_chk.sv
      - test/tb_mem_ahb_xfer.sv

// File: compile.f
+incdir+include
rtl/mem_cmd_pkg.sv
rtl/mem_rd_pkg.sv
rtl/ahb_cmd_fetch.sv
rtl/ahb_burst_decode.sv
rtl/mem_cmd_issue.sv
rtl/mem_rd_return.sv
rtl/mem_ahb_xfer_top.sv
test/tb_mem_ahb_xfer_chk.sv
test/tb_mem_ahb_xfer.sv

// File: include/mem_xfer_config.svh
//////////////////////////////////////////////////
// memory transfer bridge widths
//////////////////////////////////////////////////

`ifndef MEM_XFER_CONFIG_SVH
`define MEM_XFER_CONFIG_SVH

// ahb side
`define MEM_AHB_ADDR_WIDTH 32
`define MEM_AHB_DATA_WIDTH 32

// beats minus one, covers the 1023 of an undefined incr
`define MEM_LEN_WIDTH 10

// memory words per command
`define MEM_XFER_LEN_WIDTH 10

// flush ack is held back so the read fifo empty status can settle
`define MEM_FLUSH_ACK_DELAY 3

`endif

// File: rtl/ahb_burst_decode.sv
//////////////////////////////////////////////////
// burst table decode stage
//////////////////////////////////////////////////

`default_nettype none

module ahb_burst_decode
	import mem_cmd_pkg::*;
(
	input  logic       mem_clk,
	input  logic       mem_rst_n,
	input  logic       entry_valid,
	input  cmd_entry_t entry,
	input  logic       hold,
	output logic       fetch_hold,
	output logic       cmd_valid,
	output mem_cmd_t   cmd
);

	mem_cmd_t nxt_cmd;
	logic     load;

	assign load       = !cmd_valid || !hold;
	assign fetch_hold = cmd_valid && hold;

	//////////////////////////////////////////////////
	// burst table, 32 bit data bus
	//////////////////////////////////////////////////

	always_comb
	begin
		nxt_cmd.addr      = entry.addr;
		nxt_cmd.size      = entry.size;
		nxt_cmd.write     = entry.write;
		nxt_cmd.mr_access = entry.mr_access;
		nxt_cmd.burst     = MEM_INCR;
		nxt_cmd.len       = ahb_len_t'(0);
		nxt_cmd.xfer_len  = xfer_len_t'(1);

		case (entry.hburst)
			HBURST_SINGLE:
			begin
				case (entry.size)
					3'd0, 3'd1: nxt_cmd.xfer_len = xfer_len_t'(1);
					3'd2:       nxt_cmd.xfer_len = xfer_len_t'(2);
					3'd3:       nxt_cmd.xfer_len = xfer_len_t'(4);
					default:    nxt_cmd.xfer_len = xfer_len_t'(8);
				endcase
			end
			HBURST_INCR:
			begin
				// undefined length, assume the longest
				case (entry.size)
					3'd0:    nxt_cmd.len = ahb_len_t'(1023);
					3'd1:    nxt_cmd.len = ahb_len_t'(511);
					default: nxt_cmd.len = ahb_len_t'(255);
				endcase
				nxt_cmd.xfer_len = xfer_len_t'(512);
			end
			HBURST_WRAP4:
			begin
				nxt_cmd.len   = ahb_len_t'(3);
				nxt_cmd.burst = MEM_WRAP;
				case (entry.size)
					3'd2:    nxt_cmd.xfer_len = xfer_len_t'(8);
					3'd3:    nxt_cmd.xfer_len = xfer_len_t'(16);
					default: nxt_cmd.xfer_len = xfer_len_t'(32);
				endcase
			end
			HBURST_INCR4:
			begin
				nxt_cmd.len = ahb_len_t'(3);
				case (entry.size)
					3'd0:    nxt_cmd.xfer_len = entry.addr[0] ? xfer_len_t'(3) : xfer_len_t'(2);
					3'd1:    nxt_cmd.xfer_len = xfer_len_t'(4);
					3'd2:    nxt_cmd.xfer_len = xfer_len_t'(8);
					3'd3:    nxt_cmd.xfer_len = xfer_len_t'(16);
					default: nxt_cmd.xfer_len = xfer_len_t'(32);
				endcase
			end
			HBURST_WRAP8:
			begin
				nxt_cmd.len   = ahb_len_t'(7);
				nxt_cmd.burst = MEM_WRAP;
				case (entry.size)
					3'd1:    nxt_cmd.xfer_len = xfer_len_t'(8);
					3'd2:    nxt_cmd.xfer_len = xfer_len_t'(16);
					default: nxt_cmd.xfer_len = xfer_len_t'(32);
				endcase
			end
			HBURST_INCR8:
			begin
				nxt_cmd.len = ahb_len_t'(7);
				case (entry.size)
					3'd0:    nxt_cmd.xfer_len = entry.addr[0] ? xfer_len_t'(5) : xfer_len_t'(4);
					3'd1:    nxt_cmd.xfer_len = xfer_len_t'(8);
					3'd2:    nxt_cmd.xfer_len = xfer_len_t'(16);
					3'd3:    nxt_cmd.xfer_len = xfer_len_t'(32);
					default: nxt_cmd.xfer_len = xfer_len_t'(64);
				endcase
			end
			HBURST_WRAP16:
			begin
				nxt_cmd.len   = ahb_len_t'(15);
				nxt_cmd.burst = MEM_WRAP;
				case (entry.size)
					3'd0:    nxt_cmd.xfer_len = xfer_len_t'(8);
					3'd1:    nxt_cmd.xfer_len = xfer_len_t'(16);
					default: nxt_cmd.xfer_len = xfer_len_t'(32);
				endcase
			end
			default:	// incr16
			begin
				nxt_cmd.len = ahb_len_t'(15);
				case (entry.size)
					3'd0:    nxt_cmd.xfer_len = entry.addr[0] ? xfer_len_t'(9) : xfer_len_t'(8);
					3'd1:    nxt_cmd.xfer_len = xfer_len_t'(16);
					3'd2:    nxt_cmd.xfer_len = xfer_len_t'(32);
					3'd3:    nxt_cmd.xfer_len = xfer_len_t'(64);
					default: nxt_cmd.xfer_len = xfer_len_t'(128);
				endcase
			end
		endcase
	end

	always_ff @(posedge mem_clk or negedge mem_rst_n)
	begin
		if (!mem_rst_n)
			cmd_valid <= 1'b0;
		else if (load)
			cmd_valid <= entry_valid;
	end

	always_ff @(posedge mem_clk)
	begin
		if (load && entry_valid)
			cmd <= nxt_cmd;
	end

endmodule

`default_nettype wire

// File: rtl/ahb_cmd_fetch.sv
//////////////////////////////////////////////////
// command fifo fetch stage
//////////////////////////////////////////////////

`default_nettype none

module ahb_cmd_fetch
	import mem_cmd_pkg::*;
(
	input  logic       mem_clk,
	input  logic       mem_rst_n,
	input  logic       ahb_cmd_ff_empty,
	input  cmd_entry_t ahb_cmd_ff_data,
	output logic       ahb_cmd_ff_rden,
	input  logic       hold,
	output logic       entry_valid,
	output cmd_entry_t entry
);

	logic pop_pend;	// fifo data arrives this cycle

	// pop only into an empty slot with nothing in flight
	assign ahb_cmd_ff_rden = !ahb_cmd_ff_empty && !entry_valid && !pop_pend;

	//////////////////////////////////////////////////
	// slot control
	//////////////////////////////////////////////////

	always_ff @(posedge mem_clk or negedge mem_rst_n)
	begin
		if (!mem_rst_n)
		begin
			pop_pend    <= 1'b0;
			entry_valid <= 1'b0;
		end
		else
		begin
			pop_pend <= ahb_cmd_ff_rden;
			if (pop_pend)
				entry_valid <= 1'b1;
			else if (!hold)
				entry_valid <= 1'b0;	// decode took it
		end
	end

	// one cycle read latency on the fifo
	always_ff @(posedge mem_clk)
	begin
		if (pop_pend)
			entry <= ahb_cmd_ff_data;
	end

endmodule

`default_nettype wire

// File: rtl/mem_ahb_xfer_top.sv
//////////////////////////////////////////////////
// ahb to memory transfer bridge
//////////////////////////////////////////////////

`default_nettype none

module mem_ahb_xfer_top
	import mem_cmd_pkg::*;
	import mem_rd_pkg::*;
(
	input  logic        mem_clk,
	input  logic        mem_rst_n,
	// command fifo
	input  logic        ahb_cmd_ff_empty,
	input  cmd_entry_t  ahb_cmd_ff_data,
	output logic        ahb_cmd_ff_rden,
	// controller command
	output mem_cmd_t    ahb_cmd,
	output logic        ahb_cmd_valid,
	input  logic        ahb_cmd_ready,
	output logic        wr_start_en,
	// controller read data
	input  logic        ahb_rdata_valid,
	input  rdata_t      ahb_rdata,
	input  logic        ahb_rdata_last,
	input  logic        ahb_rdata_resp,
	output logic        ahb_rdata_ready,
	// read data fifo
	output logic        ahb_rd_ff_wren,
	output rd_ff_word_t ahb_rd_ff_data,
	input  logic        ahb_rd_ff_full,
	// flush
	input  logic        rd_fifo_flush_start,
	input  logic        dq_rdata_flush_done,
	output logic        rd_fifo_flush_ack_out
);

	logic       entry_valid;
	cmd_entry_t entry;
	logic       fetch_hold;
	logic       dec_valid;
	mem_cmd_t   dec_cmd;
	logic       decode_hold;

	ahb_cmd_fetch i_fetch (
		.mem_clk          (mem_clk),
		.mem_rst_n        (mem_rst_n),
		.ahb_cmd_ff_empty (ahb_cmd_ff_empty),
		.ahb_cmd_ff_data  (ahb_cmd_ff_data),
		.ahb_cmd_ff_rden  (ahb_cmd_ff_rden),
		.hold             (fetch_hold),
		.entry_valid      (entry_valid),
		.entry            (entry)
	);

	ahb_burst_decode i_decode (
		.mem_clk     (mem_clk),
		.mem_rst_n   (mem_rst_n),
		.entry_valid (entry_valid),
		.entry       (entry),
		.hold        (decode_hold),
		.fetch_hold  (fetch_hold),
		.cmd_valid   (dec_valid),
		.cmd         (dec_cmd)
	);

	mem_cmd_issue i_issue (
		.mem_clk       (mem_clk),
		.mem_rst_n     (mem_rst_n),
		.cmd_valid     (dec_valid),
		.cmd           (dec_cmd),
		.decode_hold   (decode_hold),
		.ahb_cmd_ready (ahb_cmd_ready),
		.ahb_cmd_valid (ahb_cmd_valid),
		.ahb_cmd       (ahb_cmd),
		.wr_start_en   (wr_start_en)
	);

	mem_rd_return i_rd_return (
		.mem_clk               (mem_clk),
		.mem_rst_n             (mem_rst_n),
		.ahb_rdata_valid       (ahb_rdata_valid),
		.ahb_rdata_last        (ahb_rdata_last),
		.ahb_rdata_resp        (ahb_rdata_resp),
		.ahb_rdata             (ahb_rdata),
		.ahb_rdata_ready       (ahb_rdata_ready),
		.ahb_rd_ff_full        (ahb_rd_ff_full),
		.ahb_rd_ff_wren        (ahb_rd_ff_wren),
		.ahb_rd_ff_data        (ahb_rd_ff_data),
		.rd_fifo_flush_start   (rd_fifo_flush_start),
		.dq_rdata_flush_done   (dq_rdata_flush_done),
		.rd_fifo_flush_ack_out (rd_fifo_flush_ack_out)
	);

endmodule

`default_nettype wire

// File: rtl/mem_cmd_issue.sv
//////////////////////////////////////////////////
// command issue to memory controller
//////////////////////////////////////////////////

`default_nettype none

module mem_cmd_issue
	import mem_cmd_pkg::*;
(
	input  logic     mem_clk,
	input  logic     mem_rst_n,
	input  logic     cmd_valid,
	input  mem_cmd_t cmd,
	output logic     decode_hold,
	input  logic     ahb_cmd_ready,
	output logic     ahb_cmd_valid,
	output mem_cmd_t ahb_cmd,
	output logic     wr_start_en
);

	typedef enum logic
	{
		IDLE,
		OFFER
	} issue_state_t;

	issue_state_t state;

	assign ahb_cmd_valid = (state == OFFER);
	assign decode_hold   = cmd_valid && (state == OFFER);	// only idle takes a command

	// starts the write data packer
	assign wr_start_en = ahb_cmd_valid && ahb_cmd_ready && ahb_cmd.write;

	always_ff @(posedge mem_clk or negedge mem_rst_n)
	begin
		if (!mem_rst_n)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE:    if (cmd_valid) state <= OFFER;
				default: if (ahb_cmd_ready) state <= IDLE;	// taken
			endcase
		end
	end

	// held stable while offered
	always_ff @(posedge mem_clk)
	begin
		if (state == IDLE && cmd_valid)
			ahb_cmd <= cmd;
	end

endmodule

`default_nettype wire

// File: rtl/mem_cmd_pkg.sv
//////////////////////////////////////////////////
// command side types
//////////////////////////////////////////////////

`default_nettype none

`include "mem_xfer_config.svh"

package mem_cmd_pkg;

	typedef logic [`MEM_AHB_ADDR_WIDTH-1:0] ahb_addr_t;
	typedef logic [2:0]                     ahb_hsize_t;	// 0 byte .. 3 dword
	typedef logic [`MEM_LEN_WIDTH-1:0]      ahb_len_t;
	typedef logic [`MEM_XFER_LEN_WIDTH-1:0] xfer_len_t;

	// ahb hburst encoding
	typedef enum logic [2:0]
	{
		HBURST_SINGLE = 3'd0,
		HBURST_INCR   = 3'd1,
		HBURST_WRAP4  = 3'd2,
		HBURST_INCR4  = 3'd3,
		HBURST_WRAP8  = 3'd4,
		HBURST_INCR8  = 3'd5,
		HBURST_WRAP16 = 3'd6,
		HBURST_INCR16 = 3'd7
	} ahb_hburst_t;

	// burst type seen by the memory controller
	typedef enum logic [1:0]
	{
		MEM_INCR = 2'd1,
		MEM_WRAP = 2'd2
	} mem_burst_t;

	// raw command fifo entry, bit 39 down to bit 0
	typedef struct packed
	{
		logic        mr_access;
		logic        write;
		ahb_hsize_t  size;
		ahb_hburst_t hburst;
		ahb_addr_t   addr;
	} cmd_entry_t;

	// command as offered to the controller
	typedef struct packed
	{
		ahb_addr_t  addr;
		ahb_len_t   len;
		mem_burst_t burst;
		ahb_hsize_t size;
		logic       write;
		logic       mr_access;
		xfer_len_t  xfer_len;
	} mem_cmd_t;

endpackage

`default_nettype wire

// File: rtl/mem_rd_pkg.sv
//////////////////////////////////////////////////
// read return types
//////////////////////////////////////////////////

`default_nettype none

`include "mem_xfer_config.svh"

package mem_rd_pkg;

	typedef logic [`MEM_AHB_DATA_WIDTH-1:0] rdata_t;

	// word written to the ahb read data fifo
	typedef struct packed
	{
		logic   resp;	// dqs timeout
		rdata_t data;
	} rd_ff_word_t;

endpackage

`default_nettype wire

// File: rtl/mem_rd_return.sv
//////////////////////////////////////////////////
// read data return and flush ack
//////////////////////////////////////////////////

`default_nettype none

`include "mem_xfer_config.svh"

module mem_rd_return
	import mem_rd_pkg::*;
(
	input  logic        mem_clk,
	input  logic        mem_rst_n,
	input  logic        ahb_rdata_valid,
	input  logic        ahb_rdata_last,
	input  logic        ahb_rdata_resp,
	input  rdata_t      ahb_rdata,
	output logic        ahb_rdata_ready,
	input  logic        ahb_rd_ff_full,
	output logic        ahb_rd_ff_wren,
	output rd_ff_word_t ahb_rd_ff_data,
	input  logic        rd_fifo_flush_start,
	input  logic        dq_rdata_flush_done,
	output logic        rd_fifo_flush_ack_out
);

	logic                            accept;
	logic                            flush_pend;	// last beat seen, dq flush not yet done
	logic                            flush_done;
	logic                            flush_ack;
	logic [`MEM_FLUSH_ACK_DELAY-1:0] ack_dly;

	assign accept                = ahb_rdata_valid && ahb_rdata_ready;
	assign rd_fifo_flush_ack_out = ack_dly[`MEM_FLUSH_ACK_DELAY-1];

	//////////////////////////////////////////////////
	// data path
	//////////////////////////////////////////////////

	always_ff @(posedge mem_clk or negedge mem_rst_n)
	begin
		if (!mem_rst_n)
		begin
			ahb_rdata_ready <= 1'b0;
			ahb_rd_ff_wren  <= 1'b0;
		end
		else
		begin
			// stall the controller while a flush is being started
			ahb_rdata_ready <= !ahb_rd_ff_full && !(flush_pend && rd_fifo_flush_start);
			ahb_rd_ff_wren  <= accept;
		end
	end

	always_ff @(posedge mem_clk)
	begin
		if (accept)
		begin
			ahb_rd_ff_data.resp <= ahb_rdata_resp;
			ahb_rd_ff_data.data <= ahb_rdata;
		end
	end

	//////////////////////////////////////////////////
	// flush tracking
	//////////////////////////////////////////////////

	always_ff @(posedge mem_clk or negedge mem_rst_n)
	begin
		if (!mem_rst_n)
		begin
			flush_pend <= 1'b0;
			flush_done <= 1'b0;
			flush_ack  <= 1'b0;
			ack_dly    <= '0;
		end
		else
		begin
			if (accept && ahb_rdata_last)
				flush_pend <= 1'b1;
			else if (dq_rdata_flush_done)
				flush_pend <= 1'b0;

			// a new beat invalidates an earlier flush done
			if (accept || flush_ack)
				flush_done <= 1'b0;
			else if (dq_rdata_flush_done)
				flush_done <= 1'b1;

			flush_ack <= rd_fifo_flush_start && flush_done && !flush_ack;	// single pulse
			ack_dly   <= {ack_dly[`MEM_FLUSH_ACK_DELAY-2:0], flush_ack};
		end
	end

endmodule

`default_nettype wire

// File: test/tb_mem_ahb_xfer.sv
//////////////////////////////////////////////////
// ahb to memory bridge testbench
//////////////////////////////////////////////////

`default_nettype none

module tb_mem_ahb_xfer
	import mem_cmd_pkg::*;
	import mem_rd_pkg::*;
();

	localparam int N_CMDS     = 64;
	localparam int RUN_CYCLES = 500;
	localparam int DRAIN_MAX  = 300;
	localparam int REPORT_MAX = 20;

	logic        mem_clk;
	logic        mem_rst_n;
	logic        ahb_cmd_ff_empty;
	cmd_entry_t  ahb_cmd_ff_data;
	logic        ahb_cmd_ff_rden;
	mem_cmd_t    ahb_cmd;
	logic        ahb_cmd_valid;
	logic        ahb_cmd_ready;
	logic        wr_start_en;
	logic        ahb_rdata_valid;
	rdata_t      ahb_rdata;
	logic        ahb_rdata_last;
	logic        ahb_rdata_resp;
	logic        ahb_rdata_ready;
	logic        ahb_rd_ff_wren;
	rd_ff_word_t ahb_rd_ff_data;
	logic        ahb_rd_ff_full;
	logic        rd_fifo_flush_start;
	logic        dq_rdata_flush_done;
	logic        rd_fifo_flush_ack_out;

	logic        stim_on;
	logic        run_done;
	logic        report_done;
	int          cmd_pending;
	int          check_total;
	int          error_total;

	logic [31:0] lfsr;
	cmd_entry_t  cmd_q [$];	// command fifo contents
	logic        pop_req;	// rden seen last cycle
	logic        beat_taken;
	logic        draining;
	logic        drained;
	logic [63:0] raw;
	int          cnt;

	mem_ahb_xfer_top i_dut (.*);

	tb_mem_ahb_xfer_chk i_chk (.*);

	initial
	begin
		mem_clk = 1'b0;
		forever #50 mem_clk = ~mem_clk;
	end

	//////////////////////////////////////////////////
	// galois lfsr, one step per bit
	//////////////////////////////////////////////////

	function automatic logic lfsr_bit();
		logic out;
		out  = lfsr[0];
		lfsr = {1'b0, lfsr[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);
		return out;
	endfunction

	function automatic logic [63:0] rand_bits(int width);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < width; i++)
			v = {v[62:0], lfsr_bit()};
		return v;
	endfunction

	// fifo side samples, taken mid cycle
	always @(negedge mem_clk)
	begin
		pop_req    = ahb_cmd_ff_rden;
		beat_taken = ahb_rdata_valid && ahb_rdata_ready;
	end

	// one cycle of fifo, controller and flush models
	task automatic drive_inputs();
		if (pop_req)
			ahb_cmd_ff_data = cmd_q.pop_front();	// read latency of one
		ahb_cmd_ff_empty = (cmd_q.size() == 0) || (!draining && rand_bits(2) == 0);
		ahb_cmd_ready    = draining || (rand_bits(1) != 0);
		if (!ahb_rdata_valid || beat_taken)
		begin
			ahb_rdata_valid = !draining && (rand_bits(1) != 0);
			ahb_rdata       = rdata_t'(rand_bits(32));
			ahb_rdata_resp  = (rand_bits(3) == 0);
			ahb_rdata_last  = (rand_bits(2) == 0);
		end
		ahb_rd_ff_full      = !draining && (rand_bits(2) == 3);
		rd_fifo_flush_start = !draining && (rand_bits(2) == 0);
		dq_rdata_flush_done = !draining && (rand_bits(3) == 0);
	endtask

	initial
	begin
		lfsr                = 32'd99265;
		stim_on             = 1'b0;
		run_done            = 1'b0;
		draining            = 1'b0;
		drained             = 1'b0;
		pop_req             = 1'b0;
		beat_taken          = 1'b0;
		mem_rst_n           = 1'b0;
		ahb_cmd_ff_empty    = 1'b1;
		ahb_cmd_ff_data     = '0;
		ahb_cmd_ready       = 1'b0;
		ahb_rdata_valid     = 1'b0;
		ahb_rdata           = '0;
		ahb_rdata_last      = 1'b0;
		ahb_rdata_resp      = 1'b0;
		ahb_rd_ff_full      = 1'b1;	// keeps ready low until stimulus
		rd_fifo_flush_start = 1'b0;
		dq_rdata_flush_done = 1'b0;
		for (cnt = 0; cnt < N_CMDS; cnt++)
		begin
			raw = rand_bits(40);
			cmd_q.push_back(cmd_entry_t'(raw[39:0]));
		end

		repeat (8) @(posedge mem_clk);
		#10;
		mem_rst_n = 1'b1;
		repeat (3) @(posedge mem_clk);	// idle, reset values visible
		#10;
		stim_on = 1'b1;
		drive_inputs();
		for (cnt = 1; cnt < RUN_CYCLES; cnt++)
		begin
			@(posedge mem_clk);
			#10;
			drive_inputs();
		end

		// let every command reach the controller
		draining = 1'b1;
		for (cnt = 0; cnt < DRAIN_MAX && !drained; cnt++)
		begin
			@(posedge mem_clk);
			#10;
			drained = (cmd_q.size() == 0) && (cmd_pending == 0) && !pop_req &&
				!ahb_cmd_valid && !ahb_rdata_valid;
			drive_inputs();
		end

		if (!drained)
			$display("Error: commands still in flight after %0d drain cycles", DRAIN_MAX);
		else
		begin
			repeat (8) @(posedge mem_clk);	// flush ack line empties
			#10;
			run_done = 1'b1;
			for (cnt = 0; cnt < REPORT_MAX && !report_done; cnt++)
				@(posedge mem_clk);
			if (!report_done)
				$display("Error: checker gave no final report");
		end

		if (drained && report_done)
			$display("checks %0d, errors %0d", check_total, error_total);
		if (drained && report_done && error_total == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/tb_mem_ahb_xfer_chk.sv
//////////////////////////////////////////////////
// bridge response checker
//////////////////////////////////////////////////

`default_nettype none

`include "mem_xfer_config.svh"

module tb_mem_ahb_xfer_chk
	import mem_cmd_pkg::*;
	import mem_rd_pkg::*;
(
	input  logic        mem_clk,
	input  logic        mem_rst_n,
	input  logic        stim_on,
	input  logic        run_done,
	input  logic        ahb_cmd_ff_rden,
	input  cmd_entry_t  ahb_cmd_ff_data,
	input  mem_cmd_t    ahb_cmd,
	input  logic        ahb_cmd_valid,
	input  logic        ahb_cmd_ready,
	input  logic        wr_start_en,
	input  logic        ahb_rdata_valid,
	input  rdata_t      ahb_rdata,
	input  logic        ahb_rdata_last,
	input  logic        ahb_rdata_resp,
	input  logic        ahb_rdata_ready,
	input  logic        ahb_rd_ff_wren,
	input  rd_ff_word_t ahb_rd_ff_data,
	input  logic        ahb_rd_ff_full,
	input  logic        rd_fifo_flush_start,
	input  logic        dq_rdata_flush_done,
	input  logic        rd_fifo_flush_ack_out,
	output int          cmd_pending,
	output logic        report_done,
	output int          check_total,
	output int          error_total
);

	int                              chk_cnt [1:5];
	int                              err_cnt [1:5];
	mem_cmd_t                        exp_cmd_q [$];
	rd_ff_word_t                     exp_beat_q [$];
	logic                            pop_seen;
	logic                            hold_seen;	// offered, not taken
	mem_cmd_t                        held_cmd;
	logic                            acc_seen;
	logic                            full_seen;
	logic                            force_seen;	// pending flush and start
	logic                            m_pend;
	logic                            m_done;
	logic [`MEM_FLUSH_ACK_DELAY:0]   ack_pipe;	// bit 0 is the internal ack

	initial
	begin
		for (int t = 1; t <= 5; t++)
		begin
			chk_cnt[t] = 0;
			err_cnt[t] = 0;
		end
		cmd_pending = 0;
		report_done = 1'b0;
		check_total = 0;
		error_total = 0;
	end

	task automatic flag_mismatch(int t, string name, logic [63:0] exp, logic [63:0] got);
		$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
		err_cnt[t]++;
	endtask

	task automatic report_problem(int t, string msg);
		$display("Error at %0t: %s", $time, msg);
		err_cnt[t]++;
	endtask

	task automatic check_low(string name, logic v);
		chk_cnt[1]++;
		if (v !== 1'b0)
			flag_mismatch(1, name, 64'd0, {63'd0, v});
	endtask

	task automatic print_line(int t, string what);
		$display("test %0d %s: %0d checks, %0d errors", t, what, chk_cnt[t], err_cnt[t]);
	endtask

	//////////////////////////////////////////////////
	// burst table, 32 bit data
	//////////////////////////////////////////////////

	function automatic mem_cmd_t expect_cmd(cmd_entry_t e);
		mem_cmd_t c;
		int       s;
		int       k;	// log2 of the beat count
		s           = int'(e.size);
		k           = 2 + (int'(e.hburst) - 2) / 2;
		c.addr      = e.addr;
		c.size      = e.size;
		c.write     = e.write;
		c.mr_access = e.mr_access;
		c.burst     = MEM_INCR;
		c.len       = '0;
		if (e.hburst == HBURST_SINGLE)
			c.xfer_len = xfer_len_t'((s < 2) ? 1 : (s == 2) ? 2 : (s == 3) ? 4 : 8);
		else if (e.hburst == HBURST_INCR)
		begin
			c.len      = ahb_len_t'((s == 0) ? 1023 : (s == 1) ? 511 : 255);
			c.xfer_len = xfer_len_t'(512);
		end
		else
		begin
			c.len = ahb_len_t'((1 << k) - 1);
			if (!e.hburst[0])	// wraps have even codes
			begin
				c.burst    = MEM_WRAP;
				c.xfer_len = xfer_len_t'((s + k == 4) ? 8 : (s + k == 5) ? 16 : 32);
			end
			else if (s == 0)
				c.xfer_len = xfer_len_t'((1 << (k - 1)) + e.addr[0]);
			else
				c.xfer_len = xfer_len_t'((1 << k) << (((s > 4) ? 4 : s) - 1));
		end
		return c;
	endfunction

	always @(negedge mem_clk)
	begin : watch
		mem_cmd_t    exp;
		rd_ff_word_t beat;
		logic        accept;
		logic        cond;
		logic        exp_ready;
		logic        exp_wr;
		accept = ahb_rdata_valid && ahb_rdata_ready;
		if (!stim_on)
		begin
			check_low("ahb_cmd_ff_rden", ahb_cmd_ff_rden);
			check_low("ahb_cmd_valid", ahb_cmd_valid);
			check_low("wr_start_en", wr_start_en);
			check_low("ahb_rdata_ready", ahb_rdata_ready);
			check_low("ahb_rd_ff_wren", ahb_rd_ff_wren);
			check_low("rd_fifo_flush_ack_out", rd_fifo_flush_ack_out);
		end
		if (!mem_rst_n)
		begin
			exp_cmd_q.delete();
			exp_beat_q.delete();
			m_pend   = 1'b0;
			m_done   = 1'b0;
			ack_pipe = '0;
		end
		else
		begin
			// command side
			exp_wr = 1'b0;
			if (pop_seen)
				exp_cmd_q.push_back(expect_cmd(ahb_cmd_ff_data));
			if (ahb_cmd_valid && ahb_cmd_ready)
			begin
				chk_cnt[2]++;
				if (exp_cmd_q.size() == 0)
					report_problem(2, "command transferred with none expected");
				else
				begin
					exp    = exp_cmd_q.pop_front();
					exp_wr = exp.write;	// write start comes from the model
					if (ahb_cmd !== exp)
						flag_mismatch(2, "ahb_cmd", exp, ahb_cmd);
				end
			end
			if (hold_seen)
			begin
				chk_cnt[3]++;
				if (!ahb_cmd_valid)
					report_problem(3, "ahb_cmd_valid dropped before the command was taken");
				if (ahb_cmd !== held_cmd)
					flag_mismatch(3, "ahb_cmd", held_cmd, ahb_cmd);
			end
			chk_cnt[3]++;
			if (wr_start_en !== exp_wr)
				flag_mismatch(3, "wr_start_en", exp_wr, wr_start_en);

			// read data path
			chk_cnt[4]++;
			if (acc_seen)
				beat = exp_beat_q.pop_front();
			if (ahb_rd_ff_wren !== acc_seen)
				flag_mismatch(4, "ahb_rd_ff_wren", acc_seen, ahb_rd_ff_wren);
			else if (acc_seen && ahb_rd_ff_data !== beat)
				flag_mismatch(4, "ahb_rd_ff_data", beat, ahb_rd_ff_data);
			exp_ready = !full_seen && !force_seen;
			chk_cnt[force_seen ? 5 : 4]++;
			if (ahb_rdata_ready !== exp_ready)
				flag_mismatch(force_seen ? 5 : 4, "ahb_rdata_ready", exp_ready, ahb_rdata_ready);

			// flush model
			chk_cnt[5]++;
			if (rd_fifo_flush_ack_out !== ack_pipe[`MEM_FLUSH_ACK_DELAY])
				flag_mismatch(5, "rd_fifo_flush_ack_out", ack_pipe[`MEM_FLUSH_ACK_DELAY],
					rd_fifo_flush_ack_out);
			cond = rd_fifo_flush_start && m_done && !ack_pipe[0];
			if (accept || ack_pipe[0])
				m_done = 1'b0;
			else if (dq_rdata_flush_done)
				m_done = 1'b1;
			force_seen = m_pend && rd_fifo_flush_start;
			if (accept && ahb_rdata_last)
				m_pend = 1'b1;
			else if (dq_rdata_flush_done)
				m_pend = 1'b0;
			ack_pipe = {ack_pipe[`MEM_FLUSH_ACK_DELAY-1:0], cond};
			if (accept)
				exp_beat_q.push_back({ahb_rdata_resp, ahb_rdata});
		end
		if (!mem_rst_n)
			force_seen = 1'b0;
		pop_seen    = mem_rst_n && ahb_cmd_ff_rden;
		acc_seen    = mem_rst_n && accept;
		hold_seen   = mem_rst_n && ahb_cmd_valid && !ahb_cmd_ready;
		held_cmd    = ahb_cmd;
		full_seen   = ahb_rd_ff_full;
		cmd_pending = exp_cmd_q.size();
	end

	always @(posedge stim_on)
		print_line(1, "outputs low after reset");

	always @(posedge run_done)
	begin
		print_line(2, "command order and burst table");
		print_line(3, "command hold and write start");
		print_line(4, "read data return");
		print_line(5, "flush handling");
		for (int t = 1; t <= 5; t++)
		begin
			check_total += chk_cnt[t];
			error_total += err_cnt[t];
		end
		report_done = 1'b1;
	end

endmodule

`default_nettype wire
